// ==== common/side_ch_defines.svh ====
// widths, depths and DMA limits of the IQ side channel, included by every RTL file that sizes ports
`ifndef SIDE_CH_DEFINES_SVH
`define SIDE_CH_DEFINES_SVH

// one I or Q component
`define SIDE_CH_IQ_WIDTH 16

// gain status, top bit is the AGC lock flag
`define SIDE_CH_GPIO_WIDTH 8

`define SIDE_CH_RSSI_WIDTH 11 // signed, half dB
`define SIDE_CH_TSF_WIDTH 64

`define SIDE_CH_DMA_WIDTH 64
`define SIDE_CH_DMA_COUNT_WIDTH 14

`define SIDE_CH_MAX_DMA_SYMBOL 8192
// one UDP datagram holds at most 65507 bytes
`define SIDE_CH_MAX_DMA_SYMBOL_UDP \
	((`SIDE_CH_MAX_DMA_SYMBOL > 8188) ? 8188 : `SIDE_CH_MAX_DMA_SYMBOL)

`define SIDE_CH_IQ_BUF_ADDR_WIDTH 12 // 4096 words of pre-trigger history

// writing this register arms auto start
`define SIDE_CH_NUM_DMA_REG_ADDR 2

`endif

// ==== common/side_ch_pkg.sv ====
// word types and enums shared by the IQ side channel, referenced as side_ch_pkg::name
`include "side_ch_defines.svh"

package side_ch_pkg;

	typedef logic [2*`SIDE_CH_IQ_WIDTH-1:0] iq_sample_t; // {q, i} pair
	typedef logic [`SIDE_CH_DMA_WIDTH-1:0] dma_word_t;
	typedef logic [`SIDE_CH_DMA_COUNT_WIDTH-1:0] dma_count_t;

	typedef enum logic [1:0] {
		src_rx = 2'd0,
		src_ofdm_tx = 2'd1,
		src_tx_intf = 2'd2
	} iq_src_e;

	// numbering kept from the register map, gaps are unused codes
	typedef enum logic [4:0] {
		trig_fcs = 5'd0,
		trig_fcs_ok = 5'd1,
		trig_fcs_bad = 5'd2,
		trig_hdr_ok = 5'd4,
		trig_hdr_bad = 5'd5,
		trig_long_preamble = 5'd8,
		trig_short_preamble = 5'd9,
		trig_rssi_rise = 5'd10,
		trig_rssi_fall = 5'd11,
		trig_agc_unlock = 5'd12,
		trig_agc_lock = 5'd13,
		trig_gain_rise = 5'd14,
		trig_gain_fall = 5'd15,
		trig_tx_done = 5'd17,
		trig_tx_bb_rise = 5'd18,
		trig_tx_bb_fall = 5'd19,
		trig_tx_rf_rise = 5'd20,
		trig_tx_rf_fall = 5'd21
	} trigger_sel_e;

	typedef enum logic [1:0] {
		cap_wait,
		cap_prepare,
		cap_header,
		cap_info
	} iq_cap_state_e;

	typedef enum logic [1:0] {
		m_axis_loopback = 2'd0,
		m_axis_auto = 2'd1,
		m_axis_ext = 2'd2,
		m_axis_idle = 2'd3
	} m_axis_mode_e;

	typedef enum logic [1:0] {
		pack_status = 2'd0,
		pack_dual_iq = 2'd1
	} pack_mode_e;

endpackage

// ==== common/rx_event_if.sv ====
// receive and transmit event strobes from the PHY, driven at the top and read by the trigger logic
`timescale 1ns/1ps

interface rx_event_if;

	logic fcs_in_strobe;
	logic fcs_ok; // valid with fcs_in_strobe
	logic pkt_header_valid_strobe;
	logic pkt_header_valid;
	logic long_preamble_detected;
	logic short_preamble_detected;
	logic phy_tx_done;

	modport source (
		output fcs_in_strobe,
		output fcs_ok,
		output pkt_header_valid_strobe,
		output pkt_header_valid,
		output long_preamble_detected,
		output short_preamble_detected,
		output phy_tx_done
	);

	modport sink (
		input fcs_in_strobe,
		input fcs_ok,
		input pkt_header_valid_strobe,
		input pkt_header_valid,
		input long_preamble_detected,
		input short_preamble_detected,
		input phy_tx_done
	);

endinterface

// ==== logic/iq_trigger_gen.sv ====
// turns PHY events and level edges into the one-cycle capture trigger picked by trigger_sel
`timescale 1ns/1ps
`include "side_ch_defines.svh"

module iq_trigger_gen (
	input  logic clk,
	input  logic rstn,
	input  logic capture_en,
	rx_event_if.sink evt,
	input  side_ch_pkg::trigger_sel_e trigger_sel,
	input  logic free_run,
	input  logic signed [`SIDE_CH_RSSI_WIDTH-1:0] rssi_half_db,
	input  logic signed [`SIDE_CH_RSSI_WIDTH-1:0] rssi_th,
	input  logic [`SIDE_CH_GPIO_WIDTH-1:0] gpio_status,
	input  logic [`SIDE_CH_GPIO_WIDTH-2:0] gain_th,
	input  logic tx_bb_is_ongoing,
	input  logic tx_rf_is_ongoing,
	output logic iq_trigger
);

	localparam int LOCK_BIT = `SIDE_CH_GPIO_WIDTH-1;

	logic signed [`SIDE_CH_RSSI_WIDTH-1:0] rssi_q;
	logic [`SIDE_CH_GPIO_WIDTH-1:0] gpio_q;
	logic tx_bb_q;
	logic tx_rf_q;
	logic rssi_rise;
	logic rssi_fall;
	logic agc_unlock;
	logic agc_lock;
	logic gain_rise;
	logic gain_fall;
	logic tx_bb_rise;
	logic tx_bb_fall;
	logic tx_rf_rise;
	logic tx_rf_fall;
	logic trigger_hit;

	// previous sample and edge flags, one cycle behind the inputs
	always_ff @(posedge clk) begin
		if (!rstn) begin
			rssi_q <= '0;
			gpio_q <= '0;
			tx_bb_q <= 1'b0;
			tx_rf_q <= 1'b0;
			rssi_rise <= 1'b0;
			rssi_fall <= 1'b0;
			agc_unlock <= 1'b0;
			agc_lock <= 1'b0;
			gain_rise <= 1'b0;
			gain_fall <= 1'b0;
			tx_bb_rise <= 1'b0;
			tx_bb_fall <= 1'b0;
			tx_rf_rise <= 1'b0;
			tx_rf_fall <= 1'b0;
		end else begin
			rssi_q <= rssi_half_db;
			gpio_q <= gpio_status;
			tx_bb_q <= tx_bb_is_ongoing;
			tx_rf_q <= tx_rf_is_ongoing;
			rssi_rise <= (rssi_q < rssi_th) && (rssi_half_db >= rssi_th);
			rssi_fall <= (rssi_q >= rssi_th) && (rssi_half_db < rssi_th);
			agc_unlock <= gpio_q[LOCK_BIT] && !gpio_status[LOCK_BIT];
			agc_lock <= !gpio_q[LOCK_BIT] && gpio_status[LOCK_BIT];
			gain_rise <= (gpio_q[LOCK_BIT-1:0] < gain_th) && (gpio_status[LOCK_BIT-1:0] >= gain_th);
			gain_fall <= (gpio_q[LOCK_BIT-1:0] >= gain_th) && (gpio_status[LOCK_BIT-1:0] < gain_th);
			tx_bb_rise <= tx_bb_is_ongoing && !tx_bb_q;
			tx_bb_fall <= !tx_bb_is_ongoing && tx_bb_q;
			tx_rf_rise <= tx_rf_is_ongoing && !tx_rf_q;
			tx_rf_fall <= !tx_rf_is_ongoing && tx_rf_q;
		end
	end

	always_comb begin
		case (trigger_sel)
			side_ch_pkg::trig_fcs: trigger_hit = evt.fcs_in_strobe || free_run;
			side_ch_pkg::trig_fcs_ok: trigger_hit = evt.fcs_in_strobe && evt.fcs_ok;
			side_ch_pkg::trig_fcs_bad: trigger_hit = evt.fcs_in_strobe && !evt.fcs_ok;
			side_ch_pkg::trig_hdr_ok: trigger_hit = evt.pkt_header_valid_strobe && evt.pkt_header_valid;
			side_ch_pkg::trig_hdr_bad: trigger_hit = evt.pkt_header_valid_strobe && !evt.pkt_header_valid;
			side_ch_pkg::trig_long_preamble: trigger_hit = evt.long_preamble_detected;
			side_ch_pkg::trig_short_preamble: trigger_hit = evt.short_preamble_detected;
			side_ch_pkg::trig_rssi_rise: trigger_hit = rssi_rise;
			side_ch_pkg::trig_rssi_fall: trigger_hit = rssi_fall;
			side_ch_pkg::trig_agc_unlock: trigger_hit = agc_unlock;
			side_ch_pkg::trig_agc_lock: trigger_hit = agc_lock;
			side_ch_pkg::trig_gain_rise: trigger_hit = gain_rise;
			side_ch_pkg::trig_gain_fall: trigger_hit = gain_fall;
			side_ch_pkg::trig_tx_done: trigger_hit = evt.phy_tx_done;
			side_ch_pkg::trig_tx_bb_rise: trigger_hit = tx_bb_rise;
			side_ch_pkg::trig_tx_bb_fall: trigger_hit = tx_bb_fall;
			side_ch_pkg::trig_tx_rf_rise: trigger_hit = tx_rf_rise;
			side_ch_pkg::trig_tx_rf_fall: trigger_hit = tx_rf_fall;
			default: trigger_hit = evt.fcs_in_strobe; // unused codes fall back to fcs
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			iq_trigger <= 1'b0;
		end else begin
			iq_trigger <= capture_en && trigger_hit;
		end
	end

	// no trigger may reach the capture FSM once capture is off
	a_trigger_needs_capture: assert property (@(posedge clk) disable iff (!rstn)
		!$past(capture_en) |-> !iq_trigger);

endmodule

// ==== iq_capture/iq_ring_buffer.sv ====
// simple dual-port RAM with registered read that keeps the packed sample history
`timescale 1ns/1ps
`include "side_ch_defines.svh"

module iq_ring_buffer (
	input  logic clk,
	input  logic wr_en,
	input  logic [`SIDE_CH_IQ_BUF_ADDR_WIDTH-1:0] wr_addr,
	input  side_ch_pkg::dma_word_t wr_data,
	input  logic [`SIDE_CH_IQ_BUF_ADDR_WIDTH-1:0] rd_addr,
	output side_ch_pkg::dma_word_t rd_data
);

	localparam int DEPTH = 1 << `SIDE_CH_IQ_BUF_ADDR_WIDTH;

	side_ch_pkg::dma_word_t mem [0:DEPTH-1];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr]; // old data on same-address collision
	end

endmodule

// ==== iq_capture/iq_capture_ctrl.sv ====
// writes the selected IQ source into the ring and streams a timestamped pre-trigger window
`timescale 1ns/1ps
`include "side_ch_defines.svh"

module iq_capture_ctrl (
	input  logic clk,
	input  logic rstn,
	input  logic capture_en,
	input  side_ch_pkg::iq_src_e iq_src,
	input  side_ch_pkg::pack_mode_e pack_mode,
	input  side_ch_pkg::iq_sample_t iq0,
	input  side_ch_pkg::iq_sample_t iq1,
	input  logic iq_strobe,
	input  side_ch_pkg::iq_sample_t ofdm_tx_iq0,
	input  side_ch_pkg::iq_sample_t ofdm_tx_iq1,
	input  logic ofdm_tx_iq_valid,
	input  side_ch_pkg::iq_sample_t tx_intf_iq0,
	input  side_ch_pkg::iq_sample_t tx_intf_iq1,
	input  logic tx_intf_iq_valid,
	input  logic signed [`SIDE_CH_RSSI_WIDTH-1:0] rssi_half_db,
	input  logic [`SIDE_CH_GPIO_WIDTH-1:0] gpio_status,
	input  logic [`SIDE_CH_TSF_WIDTH-1:0] tsf_runtime_val,
	input  logic iq_trigger,
	input  side_ch_pkg::dma_count_t pre_trigger_len,
	input  side_ch_pkg::dma_count_t iq_len_target,
	input  side_ch_pkg::dma_count_t m_axis_data_count,
	output side_ch_pkg::dma_word_t side_info,
	output logic side_info_valid
);

	localparam int AW = `SIDE_CH_IQ_BUF_ADDR_WIDTH;

	side_ch_pkg::iq_cap_state_e state;
	side_ch_pkg::iq_sample_t iq0_sel;
	side_ch_pkg::iq_sample_t iq1_sel;
	logic strobe_sel;
	logic wr_en;
	side_ch_pkg::dma_word_t wr_word;
	side_ch_pkg::dma_word_t rd_word;
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] rd_addr;
	logic [`SIDE_CH_TSF_WIDTH-1:0] tsf_lock;
	side_ch_pkg::dma_count_t sample_cnt;
	logic [`SIDE_CH_DMA_COUNT_WIDTH+1:0] burst_need;
	logic sample_take;

	always_comb begin
		case (iq_src)
			side_ch_pkg::src_rx: begin
				iq0_sel = iq0;
				iq1_sel = iq1;
				strobe_sel = iq_strobe;
			end
			side_ch_pkg::src_ofdm_tx: begin
				iq0_sel = ofdm_tx_iq0;
				iq1_sel = ofdm_tx_iq1;
				strobe_sel = ofdm_tx_iq_valid;
			end
			default: begin
				iq0_sel = tx_intf_iq0;
				iq1_sel = tx_intf_iq1;
				strobe_sel = tx_intf_iq_valid;
			end
		endcase
	end

	assign wr_en = capture_en && strobe_sel;
	assign wr_word = (pack_mode == side_ch_pkg::pack_dual_iq) ? {iq1_sel, iq0_sel} :
		{5'd0, rssi_half_db, 8'd0, gpio_status, iq0_sel};

	// header plus samples must fit below the UDP limit
	assign burst_need = m_axis_data_count + iq_len_target + 1'b1;

	assign sample_take = (state == side_ch_pkg::cap_info) && strobe_sel &&
		(sample_cnt != iq_len_target);
	assign rd_addr = sample_take ? rd_ptr + 1'b1 : rd_ptr; // read ahead for back-to-back strobes

	iq_ring_buffer i_iq_ring_buffer (
		.clk(clk),
		.wr_en(wr_en),
		.wr_addr(wr_ptr),
		.wr_data(wr_word),
		.rd_addr(rd_addr),
		.rd_data(rd_word)
	);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_ptr <= '0;
		end else if (wr_en) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= side_ch_pkg::cap_wait;
			rd_ptr <= '0;
			sample_cnt <= '0;
			side_info_valid <= 1'b0;
		end else if (!capture_en) begin
			state <= side_ch_pkg::cap_wait;
			side_info_valid <= 1'b0;
		end else begin
			side_info_valid <= 1'b0;
			case (state)
				side_ch_pkg::cap_wait: begin
					sample_cnt <= '0;
					if (iq_trigger) begin
						rd_ptr <= wr_ptr - pre_trigger_len[AW-1:0];
						state <= side_ch_pkg::cap_prepare;
					end
				end
				side_ch_pkg::cap_prepare: begin
					if (burst_need > `SIDE_CH_MAX_DMA_SYMBOL_UDP) begin
						state <= side_ch_pkg::cap_wait; // DMA FIFO too full, drop burst
					end else begin
						state <= side_ch_pkg::cap_header;
					end
				end
				side_ch_pkg::cap_header: begin
					side_info_valid <= 1'b1;
					state <= side_ch_pkg::cap_info;
				end
				default: begin
					if (sample_take) begin
						rd_ptr <= rd_ptr + 1'b1;
						sample_cnt <= sample_cnt + 1'b1;
						side_info_valid <= 1'b1;
					end else if (sample_cnt == iq_len_target) begin
						state <= side_ch_pkg::cap_wait;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == side_ch_pkg::cap_wait && iq_trigger) begin
			tsf_lock <= tsf_runtime_val;
		end
		if (state == side_ch_pkg::cap_header) begin
			side_info <= tsf_lock;
		end else if (sample_take) begin
			side_info <= rd_word;
		end
	end

	a_no_valid_in_wait: assert property (@(posedge clk) disable iff (!rstn)
		state == side_ch_pkg::cap_wait |-> !side_info_valid);

	// a burst never runs past its length, or it would never end
	a_count_in_range: assert property (@(posedge clk) disable iff (!rstn)
		state == side_ch_pkg::cap_info |-> sample_cnt <= iq_len_target);

endmodule

// ==== logic/m_axis_source_mux.sv ====
// picks the m_axis data source and start pulse: s_axis loopback, capture stream or idle
`timescale 1ns/1ps
`include "side_ch_defines.svh"

module m_axis_source_mux (
	input  logic clk,
	input  logic rstn,
	input  side_ch_pkg::m_axis_mode_e mode,
	input  logic slv_reg_wren,
	input  logic [4:0] axi_awaddr_core,
	input  logic ext_trigger,
	input  side_ch_pkg::dma_word_t side_info,
	input  logic side_info_valid,
	input  side_ch_pkg::dma_word_t data_to_pl,
	input  logic emptyn_to_pl,
	input  logic s_axis_tlast,
	output logic pl_ask_data,
	output logic m_axis_start_1trans,
	output side_ch_pkg::dma_word_t data_to_ps,
	output logic data_to_ps_valid
);

	logic reg_wr;
	logic reg_wr_q;
	logic wr_edge_d1;
	logic auto_start; // second stage of the write edge

	assign reg_wr = slv_reg_wren && (axi_awaddr_core == `SIDE_CH_NUM_DMA_REG_ADDR);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			reg_wr_q <= 1'b0;
			wr_edge_d1 <= 1'b0;
			auto_start <= 1'b0;
		end else begin
			reg_wr_q <= reg_wr;
			wr_edge_d1 <= reg_wr && !reg_wr_q;
			auto_start <= wr_edge_d1;
		end
	end

	always_comb begin
		pl_ask_data = 1'b0;
		m_axis_start_1trans = 1'b0;
		data_to_ps = '0;
		data_to_ps_valid = 1'b0;
		case (mode)
			side_ch_pkg::m_axis_loopback: begin
				pl_ask_data = 1'b1;
				m_axis_start_1trans = s_axis_tlast;
				data_to_ps = data_to_pl;
				data_to_ps_valid = emptyn_to_pl;
			end
			side_ch_pkg::m_axis_auto: begin
				m_axis_start_1trans = auto_start;
				data_to_ps = side_info;
				data_to_ps_valid = side_info_valid;
			end
			side_ch_pkg::m_axis_ext: begin
				m_axis_start_1trans = ext_trigger;
				data_to_ps = side_info;
				data_to_ps_valid = side_info_valid;
			end
			default: begin
			end
		endcase
	end

	a_idle_quiet: assert property (@(posedge clk) disable iff (!rstn)
		mode == side_ch_pkg::m_axis_idle |-> !data_to_ps_valid && !m_axis_start_1trans);

endmodule

// ==== logic/side_ch_iq_top.sv ====
// top of the IQ snapshot path, plain ports toward the PHY, register file and DMA
`timescale 1ns/1ps
`include "side_ch_defines.svh"

module side_ch_iq_top (
	input  logic clk,
	input  logic rstn,
	input  logic fcs_in_strobe,
	input  logic fcs_ok,
	input  logic pkt_header_valid_strobe,
	input  logic pkt_header_valid,
	input  logic long_preamble_detected,
	input  logic short_preamble_detected,
	input  logic phy_tx_done,
	input  logic tx_bb_is_ongoing,
	input  logic tx_rf_is_ongoing,
	input  logic [`SIDE_CH_GPIO_WIDTH-1:0] gpio_status,
	input  logic signed [`SIDE_CH_RSSI_WIDTH-1:0] rssi_half_db,
	input  logic [`SIDE_CH_TSF_WIDTH-1:0] tsf_runtime_val,
	input  logic [2*`SIDE_CH_IQ_WIDTH-1:0] iq0,
	input  logic [2*`SIDE_CH_IQ_WIDTH-1:0] iq1,
	input  logic iq_strobe,
	input  logic [2*`SIDE_CH_IQ_WIDTH-1:0] ofdm_tx_iq0,
	input  logic [2*`SIDE_CH_IQ_WIDTH-1:0] ofdm_tx_iq1,
	input  logic ofdm_tx_iq_valid,
	input  logic [2*`SIDE_CH_IQ_WIDTH-1:0] tx_intf_iq0,
	input  logic [2*`SIDE_CH_IQ_WIDTH-1:0] tx_intf_iq1,
	input  logic tx_intf_iq_valid,
	input  logic iq_capture,
	input  logic [1:0] iq_capture_cfg,
	input  logic [4:0] iq_trigger_select,
	input  logic iq_trigger_free_run_flag,
	input  logic [1:0] iq_source_select,
	input  logic [`SIDE_CH_IQ_WIDTH-1:0] rssi_or_iq_th,
	input  logic [`SIDE_CH_GPIO_WIDTH-2:0] gain_th,
	input  logic [`SIDE_CH_DMA_COUNT_WIDTH-1:0] pre_trigger_len,
	input  logic [`SIDE_CH_DMA_COUNT_WIDTH-1:0] iq_len_target,
	input  logic [1:0] m_axis_start_mode,
	input  logic m_axis_start_ext_trigger,
	input  logic slv_reg_wren,
	input  logic [4:0] axi_awaddr_core,
	input  logic [`SIDE_CH_DMA_WIDTH-1:0] data_to_pl,
	input  logic emptyn_to_pl,
	input  logic s_axis_tlast,
	output logic pl_ask_data,
	input  logic [`SIDE_CH_DMA_COUNT_WIDTH-1:0] m_axis_data_count,
	output logic m_axis_start_1trans,
	output logic [`SIDE_CH_DMA_WIDTH-1:0] data_to_ps,
	output logic data_to_ps_valid
);

	logic iq_trigger;
	side_ch_pkg::dma_word_t side_info;
	logic side_info_valid;

	rx_event_if evt_if ();

	assign evt_if.fcs_in_strobe = fcs_in_strobe;
	assign evt_if.fcs_ok = fcs_ok;
	assign evt_if.pkt_header_valid_strobe = pkt_header_valid_strobe;
	assign evt_if.pkt_header_valid = pkt_header_valid;
	assign evt_if.long_preamble_detected = long_preamble_detected;
	assign evt_if.short_preamble_detected = short_preamble_detected;
	assign evt_if.phy_tx_done = phy_tx_done;

	iq_trigger_gen i_iq_trigger_gen (
		.clk(clk),
		.rstn(rstn),
		.capture_en(iq_capture),
		.evt(evt_if.sink),
		.trigger_sel(side_ch_pkg::trigger_sel_e'(iq_trigger_select)),
		.free_run(iq_trigger_free_run_flag),
		.rssi_half_db(rssi_half_db),
		.rssi_th(rssi_or_iq_th[`SIDE_CH_RSSI_WIDTH-1:0]), // upper bits only for IQ thresholds
		.gpio_status(gpio_status),
		.gain_th(gain_th),
		.tx_bb_is_ongoing(tx_bb_is_ongoing),
		.tx_rf_is_ongoing(tx_rf_is_ongoing),
		.iq_trigger(iq_trigger)
	);

	iq_capture_ctrl i_iq_capture_ctrl (
		.clk(clk),
		.rstn(rstn),
		.capture_en(iq_capture),
		.iq_src(side_ch_pkg::iq_src_e'(iq_source_select)),
		.pack_mode(side_ch_pkg::pack_mode_e'(iq_capture_cfg)),
		.iq0(iq0),
		.iq1(iq1),
		.iq_strobe(iq_strobe),
		.ofdm_tx_iq0(ofdm_tx_iq0),
		.ofdm_tx_iq1(ofdm_tx_iq1),
		.ofdm_tx_iq_valid(ofdm_tx_iq_valid),
		.tx_intf_iq0(tx_intf_iq0),
		.tx_intf_iq1(tx_intf_iq1),
		.tx_intf_iq_valid(tx_intf_iq_valid),
		.rssi_half_db(rssi_half_db),
		.gpio_status(gpio_status),
		.tsf_runtime_val(tsf_runtime_val),
		.iq_trigger(iq_trigger),
		.pre_trigger_len(pre_trigger_len),
		.iq_len_target(iq_len_target),
		.m_axis_data_count(m_axis_data_count),
		.side_info(side_info),
		.side_info_valid(side_info_valid)
	);

	m_axis_source_mux i_m_axis_source_mux (
		.clk(clk),
		.rstn(rstn),
		.mode(side_ch_pkg::m_axis_mode_e'(m_axis_start_mode)),
		.slv_reg_wren(slv_reg_wren),
		.axi_awaddr_core(axi_awaddr_core),
		.ext_trigger(m_axis_start_ext_trigger),
		.side_info(side_info),
		.side_info_valid(side_info_valid),
		.data_to_pl(data_to_pl),
		.emptyn_to_pl(emptyn_to_pl),
		.s_axis_tlast(s_axis_tlast),
		.pl_ask_data(pl_ask_data),
		.m_axis_start_1trans(m_axis_start_1trans),
		.data_to_ps(data_to_ps),
		.data_to_ps_valid(data_to_ps_valid)
	);

endmodule

// ==== testbench/side_ch_iq_model.svh ====
// reference model for the IQ side-channel testbench, included inside the testbench module
`ifndef SIDE_CH_IQ_MODEL_SVH
`define SIDE_CH_IQ_MODEL_SVH

// every word the ring should hold, by absolute write index
logic [`SIDE_CH_DMA_WIDTH-1:0] written [$];

// status mode puts rssi and gain above iq0, dual mode stacks iq1 over iq0
function automatic logic [`SIDE_CH_DMA_WIDTH-1:0] pack_word(input logic dual,
	input logic [`SIDE_CH_RSSI_WIDTH-1:0] rssi, input logic [`SIDE_CH_GPIO_WIDTH-1:0] gpio,
	input logic [2*`SIDE_CH_IQ_WIDTH-1:0] s0, input logic [2*`SIDE_CH_IQ_WIDTH-1:0] s1);
	if (dual) begin
		return {s1, s0};
	end else begin
		return {5'd0, rssi, 8'd0, gpio, s0};
	end
endfunction

// level edges need one extra cycle for the previous-sample register
function automatic int trigger_latency(input logic [4:0] sel);
	if ((sel >= 5'd10 && sel <= 5'd15) || (sel >= 5'd18 && sel <= 5'd21)) begin
		return 2;
	end else begin
		return 1;
	end
endfunction

// ev is {tx_done, short, long, hdr_valid, hdr_strobe, fcs_ok, fcs_strobe}, tx is {rf, bb}
function automatic logic trigger_fires(input logic [4:0] sel, input logic [6:0] ev,
	input logic free_run,
	input logic signed [`SIDE_CH_RSSI_WIDTH-1:0] rssi_old,
	input logic signed [`SIDE_CH_RSSI_WIDTH-1:0] rssi_new,
	input logic signed [`SIDE_CH_RSSI_WIDTH-1:0] rssi_th,
	input logic [`SIDE_CH_GPIO_WIDTH-1:0] gpio_old,
	input logic [`SIDE_CH_GPIO_WIDTH-1:0] gpio_new,
	input logic [`SIDE_CH_GPIO_WIDTH-2:0] gain_th,
	input logic [1:0] tx_old, input logic [1:0] tx_new);
	logic [`SIDE_CH_GPIO_WIDTH-2:0] gain_old;
	logic [`SIDE_CH_GPIO_WIDTH-2:0] gain_new;
	gain_old = gpio_old[`SIDE_CH_GPIO_WIDTH-2:0];
	gain_new = gpio_new[`SIDE_CH_GPIO_WIDTH-2:0];
	case (sel)
		5'd0: return ev[0] || free_run;
		5'd1: return ev[0] && ev[1];
		5'd2: return ev[0] && !ev[1];
		5'd4: return ev[2] && ev[3];
		5'd5: return ev[2] && !ev[3];
		5'd8: return ev[4];
		5'd9: return ev[5];
		5'd10: return (rssi_old < rssi_th) && (rssi_new >= rssi_th);
		5'd11: return (rssi_old >= rssi_th) && (rssi_new < rssi_th);
		5'd12: return gpio_old[`SIDE_CH_GPIO_WIDTH-1] && !gpio_new[`SIDE_CH_GPIO_WIDTH-1];
		5'd13: return !gpio_old[`SIDE_CH_GPIO_WIDTH-1] && gpio_new[`SIDE_CH_GPIO_WIDTH-1];
		5'd14: return (gain_old < gain_th) && (gain_new >= gain_th);
		5'd15: return (gain_old >= gain_th) && (gain_new < gain_th);
		5'd17: return ev[6];
		5'd18: return tx_new[0] && !tx_old[0];
		5'd19: return !tx_new[0] && tx_old[0];
		5'd20: return tx_new[1] && !tx_old[1];
		5'd21: return !tx_new[1] && tx_old[1];
		default: return ev[0]; // unused codes act as plain fcs
	endcase
endfunction

`endif

// ==== testbench/tb_side_ch_iq.sv ====
// self-checking testbench for side_ch_iq_top, random PHY stimulus compared with an in-bench model
`timescale 1ns/1ps
`include "side_ch_defines.svh"

module tb_side_ch_iq;

	localparam int NUM_HDR_BURSTS = 6;
	localparam int NUM_RANDOM_CODES = 24;
	localparam int MAX_LEN = 32;
	localparam int STROBE_GAP = 4; // loose bound on mean strobe spacing
	localparam int HEADER_WINDOW = 8;
	localparam int TIMEOUT_CYCLES =
		(NUM_HDR_BURSTS + NUM_RANDOM_CODES + 2) * (MAX_LEN * STROBE_GAP + 40) + 1000;

	logic clk = 1'b0;
	logic rstn = 1'b0;
	logic fcs_in_strobe = 1'b0;
	logic fcs_ok = 1'b0;
	logic pkt_header_valid_strobe = 1'b0;
	logic pkt_header_valid = 1'b0;
	logic long_preamble_detected = 1'b0;
	logic short_preamble_detected = 1'b0;
	logic phy_tx_done = 1'b0;
	logic tx_bb_is_ongoing = 1'b0;
	logic tx_rf_is_ongoing = 1'b0;
	logic [`SIDE_CH_GPIO_WIDTH-1:0] gpio_status = '0;
	logic signed [`SIDE_CH_RSSI_WIDTH-1:0] rssi_half_db = '0;
	logic [`SIDE_CH_TSF_WIDTH-1:0] tsf_runtime_val = '0;
	logic [2*`SIDE_CH_IQ_WIDTH-1:0] iq0 = '0;
	logic [2*`SIDE_CH_IQ_WIDTH-1:0] iq1 = '0;
	logic iq_strobe = 1'b0;
	logic [2*`SIDE_CH_IQ_WIDTH-1:0] ofdm_tx_iq0 = '0;
	logic [2*`SIDE_CH_IQ_WIDTH-1:0] ofdm_tx_iq1 = '0;
	logic ofdm_tx_iq_valid = 1'b0;
	logic [2*`SIDE_CH_IQ_WIDTH-1:0] tx_intf_iq0 = '0;
	logic [2*`SIDE_CH_IQ_WIDTH-1:0] tx_intf_iq1 = '0;
	logic tx_intf_iq_valid = 1'b0;
	logic iq_capture = 1'b0;
	logic [1:0] iq_capture_cfg = 2'd0;
	logic [4:0] iq_trigger_select = 5'd4;
	logic iq_trigger_free_run_flag = 1'b0;
	logic [1:0] iq_source_select = 2'd0; // rx only
	logic [`SIDE_CH_IQ_WIDTH-1:0] rssi_or_iq_th = '0;
	logic [`SIDE_CH_GPIO_WIDTH-2:0] gain_th = 7'd64;
	logic [`SIDE_CH_DMA_COUNT_WIDTH-1:0] pre_trigger_len = 14'd16;
	logic [`SIDE_CH_DMA_COUNT_WIDTH-1:0] iq_len_target = 14'd8;
	logic [1:0] m_axis_start_mode = 2'd1;
	logic m_axis_start_ext_trigger = 1'b0;
	logic slv_reg_wren = 1'b0;
	logic [4:0] axi_awaddr_core = 5'd0;
	logic [`SIDE_CH_DMA_WIDTH-1:0] data_to_pl = '0;
	logic emptyn_to_pl = 1'b0;
	logic s_axis_tlast = 1'b0;
	logic pl_ask_data;
	logic [`SIDE_CH_DMA_COUNT_WIDTH-1:0] m_axis_data_count = '0;
	logic m_axis_start_1trans;
	logic [`SIDE_CH_DMA_WIDTH-1:0] data_to_ps;
	logic data_to_ps_valid;

	logic obs_valid = 1'b0; // outputs as seen at the last falling edge
	logic [`SIDE_CH_DMA_WIDTH-1:0] obs_data = '0;
	logic obs_start = 1'b0;
	logic [31:0] lcg_state = 32'hb303;
	int iq_count = 0;
	int cycle_count = 0;

	`include "side_ch_iq_model.svh"

	side_ch_iq_top i_side_ch_iq_top (.*);

	initial begin
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_run();
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {lcg_state[15:0], lcg_state[31:16]}; // low state bits repeat quickly
	endfunction

	task automatic stop_run();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	// one clock: note the write just taken, sample outputs, drive the next sample
	task automatic tick();
		logic [31:0] r;
		@(negedge clk);
		if (iq_capture && iq_strobe) begin
			written.push_back(pack_word(iq_capture_cfg == 2'd1, rssi_half_db, gpio_status, iq0, iq1));
		end
		obs_valid = data_to_ps_valid;
		obs_data = data_to_ps;
		obs_start = m_axis_start_1trans;
		{phy_tx_done, short_preamble_detected, long_preamble_detected, pkt_header_valid,
			pkt_header_valid_strobe, fcs_ok, fcs_in_strobe} = 7'd0;
		r = lcg_next();
		iq_strobe = (r[1:0] != 2'b00);
		if (iq_strobe) begin
			iq_count = iq_count + 1;
		end
		iq0 = 32'(iq_count); // unique per written word
		iq1 = lcg_next();
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			tick();
			check_value("data_to_ps_valid", obs_valid, 1'b0);
		end
	endtask

	task automatic check_burst(input int start, input int len);
		int waited;
		int k;
		waited = 0;
		do begin
			tick();
			waited++;
		end while (!obs_valid && waited < HEADER_WINDOW);
		if (!obs_valid) begin
			$display("no header word came within %0d cycles of the trigger", HEADER_WINDOW);
			stop_run();
		end else begin
			check_value("data_to_ps header", obs_data, tsf_runtime_val);
			for (k = 0; k < len; k++) begin
				do begin
					tick();
				end while (!obs_valid);
				check_value("data_to_ps sample", obs_data, written[start + k]);
			end
			expect_quiet(4);
		end
	endtask

	// spare is the room left over after the burst, negative means too little
	task automatic run_hdr_burst(input int spare);
		int len;
		int pre;
		int start;
		logic [31:0] r;
		len = 1 + int'(lcg_next() % MAX_LEN);
		pre = 4 + int'(lcg_next() % 64);
		r = lcg_next();
		iq_len_target = 14'(len);
		pre_trigger_len = 14'(pre);
		m_axis_data_count = 14'(`SIDE_CH_MAX_DMA_SYMBOL_UDP - len - 1 - spare);
		iq_capture_cfg = {1'b0, r[0]};
		rssi_half_db = r[26:16];
		gpio_status = r[15:8];
		tsf_runtime_val = {lcg_next(), lcg_next()};
		iq_trigger_select = 5'd4;
		repeat (4) tick();
		pkt_header_valid_strobe = 1'b1;
		pkt_header_valid = 1'b1;
		tick();
		start = written.size() - pre;
		if (spare >= 0) begin
			check_burst(start, len);
		end else begin
			expect_quiet(HEADER_WINDOW + 4);
		end
	endtask

	task automatic random_code_bursts();
		logic [31:0] r;
		logic [4:0] sel;
		logic signed [`SIDE_CH_RSSI_WIDTH-1:0] rssi_old;
		logic [`SIDE_CH_GPIO_WIDTH-1:0] gpio_old;
		logic [1:0] tx_old;
		logic fire;
		int n;
		int start;
		m_axis_start_mode = 2'd2; // ext mode carries the same stream
		m_axis_data_count = '0;
		iq_len_target = 14'd8;
		pre_trigger_len = 14'd16;
		for (n = 0; n < NUM_RANDOM_CODES; n++) begin
			sel = 5'(lcg_next() % 22);
			iq_trigger_select = sel;
			repeat (3) tick();
			rssi_old = rssi_half_db;
			gpio_old = gpio_status;
			tx_old = {tx_rf_is_ongoing, tx_bb_is_ongoing};
			r = lcg_next();
			{phy_tx_done, short_preamble_detected, long_preamble_detected, pkt_header_valid,
				pkt_header_valid_strobe, fcs_ok, fcs_in_strobe} = r[6:0];
			{tx_rf_is_ongoing, tx_bb_is_ongoing} = r[8:7];
			gpio_status = r[16:9];
			rssi_half_db = r[27:17];
			fire = trigger_fires(sel, r[6:0], iq_trigger_free_run_flag, rssi_old, rssi_half_db,
				rssi_or_iq_th[`SIDE_CH_RSSI_WIDTH-1:0], gpio_old, gpio_status, gain_th, tx_old,
				r[8:7]);
			repeat (trigger_latency(sel)) tick();
			start = written.size() - 16;
			if (fire) begin
				check_burst(start, 8);
			end else begin
				expect_quiet(HEADER_WINDOW + 4);
			end
		end
	endtask

	task automatic start_pulse_checks();
		int hold;
		int k;
		logic [31:0] r;
		m_axis_start_mode = 2'd1;
		repeat (4) begin
			hold = 1 + int'(lcg_next() % 3);
			tick();
			slv_reg_wren = 1'b1;
			axi_awaddr_core = 5'(`SIDE_CH_NUM_DMA_REG_ADDR);
			for (k = 0; k < 6; k++) begin
				tick();
				if (k + 1 == hold) begin
					slv_reg_wren = 1'b0;
				end
				check_value("m_axis_start_1trans", obs_start, k == 1);
			end
		end
		axi_awaddr_core = 5'd3; // other registers never start a transfer
		slv_reg_wren = 1'b1;
		for (k = 0; k < 6; k++) begin
			tick();
			slv_reg_wren = 1'b0;
			check_value("m_axis_start_1trans", obs_start, 1'b0);
		end
		m_axis_start_mode = 2'd2;
		repeat (8) begin
			tick();
			r = lcg_next();
			m_axis_start_ext_trigger = r[0];
			#1;
			check_value("m_axis_start_1trans", m_axis_start_1trans, r[0]);
		end
	endtask

	task automatic mux_mode_checks();
		logic [31:0] r;
		m_axis_start_mode = 2'd0;
		repeat (8) begin
			tick();
			r = lcg_next();
			data_to_pl = {lcg_next(), r};
			emptyn_to_pl = r[0];
			s_axis_tlast = r[1];
			#1;
			check_value("data_to_ps", data_to_ps, data_to_pl);
			check_value("data_to_ps_valid", data_to_ps_valid, r[0]);
			check_value("m_axis_start_1trans", m_axis_start_1trans, r[1]);
			check_value("pl_ask_data", pl_ask_data, 1'b1);
		end
		m_axis_start_mode = 2'd3;
		m_axis_start_ext_trigger = 1'b1;
		repeat (4) begin
			tick();
			data_to_pl = {lcg_next(), lcg_next()};
			emptyn_to_pl = 1'b1;
			s_axis_tlast = 1'b1;
			#1;
			check_value("data_to_ps", data_to_ps, 64'd0);
			check_value("data_to_ps_valid", data_to_ps_valid, 1'b0);
			check_value("m_axis_start_1trans", m_axis_start_1trans, 1'b0);
			check_value("pl_ask_data", pl_ask_data, 1'b0);
		end
	endtask

	initial begin
		int n;
		repeat (10) @(negedge clk);
		check_value("data_to_ps_valid", data_to_ps_valid, 1'b0);
		check_value("m_axis_start_1trans", m_axis_start_1trans, 1'b0);
		rstn = 1'b1;
		iq_capture = 1'b1;
		repeat (200) tick(); // history ahead of the first window
		for (n = 0; n < NUM_HDR_BURSTS; n++) begin
			run_hdr_burst(int'(lcg_next() % 4000));
		end
		run_hdr_burst(0); // exactly enough room
		run_hdr_burst(-1);
		random_code_bursts();
		start_pulse_checks();
		mux_mode_checks();
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+common
+incdir+testbench
common/side_ch_pkg.sv
common/rx_event_if.sv
logic/iq_trigger_gen.sv
iq_capture/iq_ring_buffer.sv
iq_capture/iq_capture_ctrl.sv
logic/m_axis_source_mux.sv
logic/side_ch_iq_top.sv
testbench/tb_side_ch_iq.sv
